// File: Bender.yml
package:
  name: rvseed_mem_wb

sources:
  - files:
      - source/rvseed_pkg.sv
      - source/data_ram.sv
      - source/mem_access.sv
      - source/mem_wb_regs.sv
      - source/wb_select.sv
      - source/reg_file.sv
      - source/mem_wb_top.sv
  - target: simulation
    files:
      - sim/mem_wb_asserts.sv
      - sim/tb_mem_wb.sv

// File: compile.f
source/rvseed_pkg.sv
source/data_ram.sv
source/mem_access.sv
source/mem_wb_regs.sv
source/wb_select.sv
source/reg_file.sv
source/mem_wb_top.sv
sim/mem_wb_asserts.sv
sim/tb_mem_wb.sv

// File: sim/mem_wb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_asserts import rvseed_pkg::*; (
    input wire logic                      clk,
    input wire logic                      rst_n,
    input wire logic                      valid_i,
    input wire logic                      stall_i,
    input wire logic                      mem_wen_i,
    input wire logic                      mem_ren_i,
    input wire logic [7:0]                wmask_i,
    input wire logic [XLEN-1:0]           alu_res_i,
    input wire logic                      ram_wen,
    input wire logic                      commit_o,
    input wire logic                      rf_wen,
    input wire logic [REG_ADDR_WIDTH-1:0] rf_waddr
);

    logic misaligned;
    int   fail_count = 0; // failed assertions so far

    assign misaligned = (wmask_i == MASK_H && alu_res_i[0])
                      || (wmask_i == MASK_W && alu_res_i[1:0] != 0)
                      || (wmask_i == MASK_D && alu_res_i[2:0] != 0);

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i && (mem_wen_i || mem_ren_i)) |-> !misaligned)
        else begin
            fail_count++;
            $error("misaligned memory access");
        end

    a_no_write_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |-> !ram_wen)
        else begin
            fail_count++;
            $error("ram written while stalled");
        end

    a_no_commit_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> !commit_o)
        else begin
            fail_count++;
            $error("commit right after a stall");
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rf_wen |-> rf_waddr != 0)
        else begin
            fail_count++;
            $error("register file write enable for x0");
        end

endmodule

bind mem_wb_top mem_wb_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (valid_i),
    .stall_i   (stall_i),
    .mem_wen_i (mem_wen_i),
    .mem_ren_i (mem_ren_i),
    .wmask_i   (wmask_i),
    .alu_res_i (alu_res_i),
    .ram_wen   (ram_wen),
    .commit_o  (commit_o),
    .rf_wen    (rf_wen),
    .rf_waddr  (rf_waddr)
);

`default_nettype wire

// File: sim/tb_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb import rvseed_pkg::*; ();

    localparam int COMMIT_TIMEOUT = 4; // cycles

    logic                      clk;
    logic                      rst_n;
    logic                      valid;
    logic                      stall;
    logic                      reg_wen;
    logic [REG_ADDR_WIDTH-1:0] reg_waddr;
    logic [XLEN-1:0]           alu_res;
    logic [XLEN-1:0]           store_data;
    logic                      mem_wen;
    logic                      mem_ren;
    logic [7:0]                wmask;
    logic [EXP_WIDTH-1:0]      expand;
    logic                      ebreak;
    logic [XLEN-1:0]           pc;
    logic [REG_ADDR_WIDTH-1:0] dbg_raddr;
    wire                       commit;
    wire                       ebreak_wb;
    wire  [XLEN-1:0]           pc_wb;
    wire  [XLEN-1:0]           dbg_rdata;

    logic [XLEN-1:0] ram_model [0:RAM_WORDS-1];
    logic [XLEN-1:0] regs_model [0:31];
    logic [XLEN-1:0] last_pc;
    logic            last_ebreak;
    logic [31:0]     rng_state;
    int              error_count;

    mem_wb_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid_i         (valid),
        .stall_i         (stall),
        .reg_wen_i       (reg_wen),
        .reg_waddr_i     (reg_waddr),
        .alu_res_i       (alu_res),
        .store_data_i    (store_data),
        .mem_wen_i       (mem_wen),
        .mem_ren_i       (mem_ren),
        .wmask_i         (wmask),
        .expand_signed_i (expand),
        .ebreak_i        (ebreak),
        .pc_i            (pc),
        .dbg_raddr_i     (dbg_raddr),
        .commit_o        (commit),
        .ebreak_o        (ebreak_wb),
        .pc_wb_o         (pc_wb),
        .dbg_rdata_o     (dbg_rdata)
    );

    always #20 clk = ~clk;

    always @(DUT.u_asserts.fail_count) begin
        if (DUT.u_asserts.fail_count != 0) begin
            $display("An assertion bound to the DUT failed");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected writeback value, built from the model bytes
    function automatic logic [63:0] wb_value(input logic [63:0] addr, input logic [3:0] code);
        logic [63:0] raw;
        raw = ram_model[addr[MEM_ADDR_WIDTH-1:3]] >> (addr[2:0] * 8);
        case (code)
            EXP_LB:  return {{56{raw[7]}}, raw[7:0]};
            EXP_LBU: return {56'h0, raw[7:0]};
            EXP_LH:  return {{48{raw[15]}}, raw[15:0]};
            EXP_LHU: return {48'h0, raw[15:0]};
            EXP_LW:  return {{32{raw[31]}}, raw[31:0]};
            EXP_LWU: return {32'h0, raw[31:0]};
            EXP_LD:  return raw;
            default: return addr;
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_commit();
        int cnt;
        cnt = 0;
        while (!commit) begin
            if (cnt == COMMIT_TIMEOUT) begin
                error_count++;
                $display("Timed out waiting for commit_o after an accepted instruction");
                $display("TEST FAILED");
                $fatal(1);
            end
            step();
            cnt++;
        end
        check("commit latency", cnt, 0); // one cycle exactly
    endtask

    // one edge with the current inputs, models updated by the stage rules
    task automatic present();
        logic        acc;
        logic [63:0] wb;
        logic [9:0]  a;
        acc = valid && !stall;
        if (acc) begin
            wb = wb_value(alu_res, expand);
            a  = alu_res[9:0];
            if (mem_wen) begin
                for (int k = 0; k < 8; k++) begin
                    if (wmask[k]) ram_model[(a + k) >> 3][((a + k) % 8) * 8 +: 8] =
                        store_data[k*8 +: 8];
                end
            end
            if (reg_wen && reg_waddr != 0) regs_model[reg_waddr] = wb;
            last_pc     = pc;
            last_ebreak = ebreak;
        end
        step();
        if (acc) wait_commit();
        else check("commit_o", commit, 0);
        check("pc_wb_o", pc_wb, last_pc);
        check("ebreak_o", ebreak_wb, last_ebreak);
        pc = pc + 4;
    endtask

    task automatic clear_inputs();
        valid      = 0;
        reg_wen    = 0;
        reg_waddr  = 0;
        alu_res    = 0;
        store_data = 0;
        mem_wen    = 0;
        mem_ren    = 0;
        wmask      = 0;
        expand     = EXP_ALU;
        ebreak     = 0;
    endtask

    task automatic set_alu(input logic [4:0] rd, input logic [63:0] val);
        clear_inputs();
        valid     = 1;
        reg_wen   = 1;
        reg_waddr = rd;
        alu_res   = val;
    endtask

    task automatic set_store(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] mask);
        clear_inputs();
        valid      = 1;
        mem_wen    = 1;
        alu_res    = addr;
        store_data = data;
        wmask      = mask;
    endtask

    task automatic set_load(input logic [4:0] rd, input logic [63:0] addr, input logic [3:0] code);
        clear_inputs();
        valid     = 1;
        mem_ren   = 1;
        reg_wen   = 1;
        reg_waddr = rd;
        alu_res   = addr;
        expand    = code;
        case (code)
            EXP_LB, EXP_LBU: wmask = MASK_B;
            EXP_LH, EXP_LHU: wmask = MASK_H;
            EXP_LW, EXP_LWU: wmask = MASK_W;
            default:         wmask = MASK_D;
        endcase
    endtask

    task automatic idle();
        clear_inputs();
        present();
    endtask

    task automatic check_reg(input int idx);
        dbg_raddr = 5'(idx);
        #1;
        check($sformatf("dbg_rdata_o x%0d", idx), dbg_rdata, regs_model[idx]);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 32; i++) check_reg(i);
    endtask

    task automatic test_reset();
        check("commit_o", commit, 0);
        check("ebreak_o", ebreak_wb, 0);
        check("pc_wb_o", pc_wb, RESET_PC);
        check_all_regs();
    endtask

    task automatic test_alu_writeback();
        set_alu(5, {xorshift(), xorshift()});
        present();
        set_alu(17, {xorshift(), xorshift()});
        present();
        set_alu(0, 64'hdead_beef_0bad_f00d); // x0 must stay zero
        present();
        idle();
        check_reg(5);
        check_reg(17);
        check_reg(0);
    endtask

    task automatic test_store_load();
        logic [3:0] codes [7];
        codes = '{EXP_LB, EXP_LBU, EXP_LH, EXP_LHU, EXP_LW, EXP_LWU, EXP_LD};
        set_store(64'h40, 64'h8877_6655_f433_2281, MASK_D);
        present();
        set_store(64'h41, 64'h0000_0000_0000_00a5, MASK_B);
        present();
        set_store(64'h4a, 64'h0000_0000_0000_9c3e, MASK_H);
        present();
        set_store(64'h4c, 64'h0000_0000_8123_4567, MASK_W);
        present();
        for (int c = 0; c < 7; c++) begin
            for (int off = 0; off < 16; off++) begin
                if ((codes[c] inside {EXP_LH, EXP_LHU}) && off % 2 != 0) continue;
                if ((codes[c] inside {EXP_LW, EXP_LWU}) && off % 4 != 0) continue;
                if (codes[c] == EXP_LD && off % 8 != 0) continue;
                set_load(1, 64'h40 + off, codes[c]);
                present();
                idle();
                check_reg(1);
            end
        end
    endtask

    task automatic test_stall();
        set_alu(9, 64'h1234);
        ebreak = 1;
        present();
        stall = 1;
        set_store(64'h100, {xorshift(), xorshift()}, MASK_D); // ignored
        present();
        set_alu(10, 64'hffff_0000_ffff_0000); // ignored
        present();
        stall = 0;
        set_load(11, 64'h100, EXP_LD); // commits normally
        present();
        idle();
        check_reg(9);
        check_reg(10);
        check_reg(11);
    endtask

    task automatic test_ebreak();
        set_alu(3, 64'h77);
        ebreak = 1;
        present();
        set_alu(4, 64'h78);
        present();
        idle();
    endtask

    task automatic test_random(input int count);
        logic [31:0] r;
        logic [63:0] addr;
        logic [3:0]  code;
        for (int n = 0; n < count; n++) begin
            r    = xorshift();
            addr = 64'(xorshift() & 32'h3ff);
            case (r % 3)
                0: set_alu(5'(xorshift() % 32), {xorshift(), xorshift()});
                1: begin
                    code = 4'(1 + xorshift() % 7);
                    case (code)
                        EXP_LH, EXP_LHU: addr[0] = 0;
                        EXP_LW, EXP_LWU: addr[1:0] = 0;
                        EXP_LD:          addr[2:0] = 0;
                        default: ;
                    endcase
                    set_load(5'(xorshift() % 32), addr, code);
                end
                default: begin
                    case (xorshift() % 4)
                        0: set_store(addr, {xorshift(), xorshift()}, MASK_B);
                        1: set_store({addr[63:1], 1'b0}, {xorshift(), xorshift()}, MASK_H);
                        2: set_store({addr[63:2], 2'b0}, {xorshift(), xorshift()}, MASK_W);
                        default: set_store({addr[63:3], 3'b0}, {xorshift(), xorshift()}, MASK_D);
                    endcase
                end
            endcase
            ebreak = r[8];
            stall  = (r[11:10] == 0);
            present();
            stall = 0;
        end
        idle();
        check_all_regs();
    endtask

    initial begin
        clk         = 0;
        rst_n       = 0;
        stall       = 0;
        pc          = RESET_PC;
        dbg_raddr   = 0;
        rng_state   = 32'hd940;
        error_count = 0;
        last_pc     = RESET_PC;
        last_ebreak = 0;
        clear_inputs();
        for (int i = 0; i < RAM_WORDS; i++) ram_model[i] = 0;
        for (int i = 0; i < 32; i++) regs_model[i] = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1;

        test_reset();
        test_alu_writeback();
        test_store_load();
        test_stall();
        test_ebreak();
        test_random(300);

        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram import rvseed_pkg::*; (
    input  wire logic                       clk,
    input  wire logic [WORD_ADDR_WIDTH-1:0] addr_i,
    input  wire logic                       wen_i,
    input  wire logic [7:0]                 byte_en_i,
    input  wire logic [XLEN-1:0]            wdata_i,
    output logic      [XLEN-1:0]            rdata_o
);

    logic [XLEN-1:0] mem [0:RAM_WORDS-1];

    // memory starts out cleared
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wen_i) begin
            for (int i = 0; i < 8; i++) begin
                if (byte_en_i[i]) begin
                    mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[addr_i]; // async read

endmodule

`default_nettype wire

// File: source/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access import rvseed_pkg::*; (
    input  wire logic                       valid_i,
    input  wire logic                       stall_i,
    input  wire logic                       mem_wen_i,
    input  wire logic [XLEN-1:0]            alu_res_i,    // also the byte address
    input  wire logic [XLEN-1:0]            store_data_i, // right aligned
    input  wire logic [7:0]                 wmask_i,      // size mask, lane 0
    output logic                            accept_o,

    output logic      [WORD_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                            ram_wen_o,
    output logic      [7:0]                 ram_byte_en_o,
    output logic      [XLEN-1:0]            ram_wdata_o,
    input  wire logic [XLEN-1:0]            ram_rdata_i,

    output logic      [XLEN-1:0]            load_word_o
);

    logic [2:0] lane; // byte offset within the doubleword

    assign lane = alu_res_i[2:0];

    // the one place stall is looked at
    assign accept_o = valid_i & ~stall_i;

    assign ram_addr_o = alu_res_i[MEM_ADDR_WIDTH-1:3];
    assign ram_wen_o  = accept_o & mem_wen_i;

    // move the mask and data up into the addressed lanes
    assign ram_byte_en_o = wmask_i << lane;
    assign ram_wdata_o   = store_data_i << {lane, 3'b000};

    // lane select and extension happen after the register
    assign load_word_o = ram_rdata_i;

endmodule

`default_nettype wire

// File: source/mem_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_regs import rvseed_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      accept_i,

    input  wire logic                      reg_wen_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] reg_waddr_i,
    input  wire logic [XLEN-1:0]           alu_res_i,
    input  wire logic [XLEN-1:0]           load_word_i,
    input  wire logic [EXP_WIDTH-1:0]      expand_signed_i,
    input  wire logic                      ebreak_i,
    input  wire logic [XLEN-1:0]           pc_i,

    output logic                           reg_wen_o,
    output logic      [REG_ADDR_WIDTH-1:0] reg_waddr_o,
    output logic      [XLEN-1:0]           alu_res_o,
    output logic      [XLEN-1:0]           load_word_o,
    output logic      [EXP_WIDTH-1:0]      expand_signed_o,
    output logic                           ebreak_o,
    output logic      [XLEN-1:0]           pc_o,
    output logic                           commit_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wen_o       <= 1'b0;
            reg_waddr_o     <= '0;
            alu_res_o       <= '0;
            load_word_o     <= '0;
            expand_signed_o <= EXP_ALU;
            ebreak_o        <= 1'b0;
            pc_o            <= RESET_PC;
        end else if (accept_i) begin
            reg_wen_o       <= reg_wen_i;
            reg_waddr_o     <= reg_waddr_i;
            alu_res_o       <= alu_res_i;
            load_word_o     <= load_word_i;
            expand_signed_o <= expand_signed_i;
            ebreak_o        <= ebreak_i;
            pc_o            <= pc_i;
        end
        // no accept: fields keep the last instruction
    end

    // one commit per accepted instruction, so a held one is
    // not written back again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_o <= 1'b0;
        end else begin
            commit_o <= accept_i;
        end
    end

endmodule

`default_nettype wire

// File: source/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top import rvseed_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    input  wire logic                      valid_i,
    input  wire logic                      stall_i,
    input  wire logic                      reg_wen_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] reg_waddr_i,
    input  wire logic [XLEN-1:0]           alu_res_i,
    input  wire logic [XLEN-1:0]           store_data_i,
    input  wire logic                      mem_wen_i,
    input  wire logic                      mem_ren_i, // only checked by assertions
    input  wire logic [7:0]                wmask_i,
    input  wire logic [EXP_WIDTH-1:0]      expand_signed_i,
    input  wire logic                      ebreak_i,
    input  wire logic [XLEN-1:0]           pc_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] dbg_raddr_i,

    output logic                           commit_o,
    output logic                           ebreak_o,
    output logic      [XLEN-1:0]           pc_wb_o,
    output logic      [XLEN-1:0]           dbg_rdata_o
);

    logic                       accept;
    logic [WORD_ADDR_WIDTH-1:0] ram_addr;
    logic                       ram_wen;
    logic [7:0]                 ram_byte_en;
    logic [XLEN-1:0]            ram_wdata;
    logic [XLEN-1:0]            ram_rdata;
    logic [XLEN-1:0]            load_word;

    // registered MEM/WB fields
    logic                       wb_reg_wen;
    logic [REG_ADDR_WIDTH-1:0]  wb_reg_waddr;
    logic [XLEN-1:0]            wb_alu_res;
    logic [XLEN-1:0]            wb_load_word;
    logic [EXP_WIDTH-1:0]       wb_expand;

    logic                       rf_wen;
    logic [REG_ADDR_WIDTH-1:0]  rf_waddr;
    logic [XLEN-1:0]            rf_wdata;

    mem_access u_mem_access (
        .valid_i       (valid_i),
        .stall_i       (stall_i),
        .mem_wen_i     (mem_wen_i),
        .alu_res_i     (alu_res_i),
        .store_data_i  (store_data_i),
        .wmask_i       (wmask_i),
        .accept_o      (accept),
        .ram_addr_o    (ram_addr),
        .ram_wen_o     (ram_wen),
        .ram_byte_en_o (ram_byte_en),
        .ram_wdata_o   (ram_wdata),
        .ram_rdata_i   (ram_rdata),
        .load_word_o   (load_word)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .addr_i    (ram_addr),
        .wen_i     (ram_wen),
        .byte_en_i (ram_byte_en),
        .wdata_i   (ram_wdata),
        .rdata_o   (ram_rdata)
    );

    mem_wb_regs u_mem_wb_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .accept_i        (accept),
        .reg_wen_i       (reg_wen_i),
        .reg_waddr_i     (reg_waddr_i),
        .alu_res_i       (alu_res_i),
        .load_word_i     (load_word),
        .expand_signed_i (expand_signed_i),
        .ebreak_i        (ebreak_i),
        .pc_i            (pc_i),
        .reg_wen_o       (wb_reg_wen),
        .reg_waddr_o     (wb_reg_waddr),
        .alu_res_o       (wb_alu_res),
        .load_word_o     (wb_load_word),
        .expand_signed_o (wb_expand),
        .ebreak_o        (ebreak_o),
        .pc_o            (pc_wb_o),
        .commit_o        (commit_o)
    );

    wb_select u_wb_select (
        .commit_i        (commit_o),
        .reg_wen_i       (wb_reg_wen),
        .reg_waddr_i     (wb_reg_waddr),
        .alu_res_i       (wb_alu_res),
        .load_word_i     (wb_load_word),
        .expand_signed_i (wb_expand),
        .rf_wen_o        (rf_wen),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wen_i   (rf_wen),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (dbg_raddr_i),
        .rdata_o (dbg_rdata_o)
    );

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rvseed_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      wen_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] waddr_i,
    input  wire logic [XLEN-1:0]           wdata_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] raddr_i,
    output logic      [XLEN-1:0]           rdata_o
);

    logic [XLEN-1:0] regs [1:(1 << REG_ADDR_WIDTH)-1]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << REG_ADDR_WIDTH); i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // debug read, sees a write only after the edge
    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

`default_nettype wire

// File: source/rvseed_pkg.sv
`default_nettype none

package rvseed_pkg;

    localparam int XLEN           = 64;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int MEM_ADDR_WIDTH = 10;                  // byte address, 1 KiB
    localparam int WORD_ADDR_WIDTH = MEM_ADDR_WIDTH - 3; // doubleword index
    localparam int RAM_WORDS      = 1 << WORD_ADDR_WIDTH;

    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // writeback extension codes
    localparam int EXP_WIDTH = 4;
    localparam logic [EXP_WIDTH-1:0] EXP_ALU = 4'd0; // alu result, no load
    localparam logic [EXP_WIDTH-1:0] EXP_LB  = 4'd1;
    localparam logic [EXP_WIDTH-1:0] EXP_LBU = 4'd2;
    localparam logic [EXP_WIDTH-1:0] EXP_LH  = 4'd3;
    localparam logic [EXP_WIDTH-1:0] EXP_LHU = 4'd4;
    localparam logic [EXP_WIDTH-1:0] EXP_LW  = 4'd5;
    localparam logic [EXP_WIDTH-1:0] EXP_LWU = 4'd6;
    localparam logic [EXP_WIDTH-1:0] EXP_LD  = 4'd7;

    // size masks, one bit per byte before lane shift
    localparam logic [7:0] MASK_B = 8'h01;
    localparam logic [7:0] MASK_H = 8'h03;
    localparam logic [7:0] MASK_W = 8'h0F;
    localparam logic [7:0] MASK_D = 8'hFF;

    // one memory word seen by lane size
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } mem_word_u;

endpackage

`default_nettype wire

// File: source/wb_select.sv
`timescale 1ns/1ps
`default_nettype none

module wb_select import rvseed_pkg::*; (
    input  wire logic                      commit_i,
    input  wire logic                      reg_wen_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] reg_waddr_i,
    input  wire logic [XLEN-1:0]           alu_res_i,
    input  wire logic [XLEN-1:0]           load_word_i,
    input  wire logic [EXP_WIDTH-1:0]      expand_signed_i,

    output logic                           rf_wen_o,
    output logic      [REG_ADDR_WIDTH-1:0] rf_waddr_o,
    output logic      [XLEN-1:0]           rf_wdata_o
);

    mem_word_u  word;
    logic [2:0] lane;
    logic [7:0]  lb;
    logic [15:0] lh;
    logic [31:0] lw;

    assign word = load_word_i;
    assign lane = alu_res_i[2:0];

    // accesses are aligned, so the low offset bits pick the lane
    assign lb = word.b[lane];
    assign lh = word.h[lane[2:1]];
    assign lw = word.w[lane[2]];

    always_comb begin
        case (expand_signed_i)
            EXP_LB:  rf_wdata_o = {{(XLEN-8){lb[7]}}, lb};
            EXP_LBU: rf_wdata_o = {{(XLEN-8){1'b0}}, lb};
            EXP_LH:  rf_wdata_o = {{(XLEN-16){lh[15]}}, lh};
            EXP_LHU: rf_wdata_o = {{(XLEN-16){1'b0}}, lh};
            EXP_LW:  rf_wdata_o = {{(XLEN-32){lw[31]}}, lw};
            EXP_LWU: rf_wdata_o = {{(XLEN-32){1'b0}}, lw};
            EXP_LD:  rf_wdata_o = word.d;
            default: rf_wdata_o = alu_res_i; // EXP_ALU and unused codes
        endcase
    end

    // x0 never sees a write strobe
    assign rf_wen_o   = commit_i & reg_wen_i & (reg_waddr_i != '0);
    assign rf_waddr_o = reg_waddr_i;

endmodule

`default_nettype wire
